// ==== hdl/memCtrlPkg.sv ====
`default_nettype none

package memCtrlPkg;

    // bus widths
    localparam int ADDR_W = 32;
    localparam int WORD_W = 32;
    localparam int BYTE_W = 8;

    // byte lanes in one word
    localparam int LANES = WORD_W / BYTE_W;

    typedef logic [$clog2(LANES)-1:0] byteIdx_t;

    // transfer length in bytes, only 1, 2 or 4 are legal
    typedef logic [2:0] xferLen_t;

    // an instruction fetch is always a full word
    localparam xferLen_t FETCH_LEN = 3'd4;

    // who holds the memory right now
    typedef enum logic [1:0] {
        ownerNone  = 2'd0,
        ownerData  = 2'd1,
        ownerFetch = 2'd2
    } memOwner_t;

    // one client transfer
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] wdata;
        xferLen_t          len;
        logic              isStore;
    } memReq_t;

    // byte-wide port towards the RAM
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [BYTE_W-1:0] wdata;
        logic              write;
    } memPort_t;

endpackage

`default_nettype wire

// ==== hdl/memArbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module memArbiter
    import memCtrlPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              advance,

    input  logic              fetchEn,
    input  logic [ADDR_W-1:0] fetchAddr,
    input  logic              dataEn,
    input  memReq_t           dataReq,

    input  logic              finishPulse,
    input  logic [WORD_W-1:0] rdata,

    output logic              startPulse,
    output memReq_t           cmd,
    output memOwner_t         busyOwner,

    output logic              fetchDone,
    output logic [WORD_W-1:0] fetchInst,
    output logic              dataDone,
    output logic [WORD_W-1:0] dataRdata
);

    memOwner_t owner;
    logic      canGrant;

    // idle, or in the last cycle of the running transfer
    assign canGrant = (owner == ownerNone) || finishPulse;

    always_ff @(posedge clk) begin
        if (rst) begin
            owner      <= ownerNone;
            startPulse <= 1'b0;
        end else if (advance) begin
            startPulse <= 1'b0;
            if (canGrant) begin
                // data unit wins a tie
                if (dataEn) begin
                    owner      <= ownerData;
                    startPulse <= 1'b1;
                end else if (fetchEn) begin
                    owner      <= ownerFetch;
                    startPulse <= 1'b1;
                end else begin
                    owner <= ownerNone;
                end
            end
        end
    end

    // latch the winning request, a fetch becomes a word load
    always_ff @(posedge clk) begin
        if (advance && canGrant) begin
            if (dataEn) begin
                cmd <= dataReq;
            end else if (fetchEn) begin
                cmd <= '{addr: fetchAddr, wdata: '0, len: FETCH_LEN, isStore: 1'b0};
            end
        end
    end

    assign busyOwner = owner;

    // reply goes to whoever owns the transfer
    assign fetchDone = advance && finishPulse && (owner == ownerFetch);
    assign dataDone  = advance && finishPulse && (owner == ownerData);

    assign fetchInst = (owner == ownerFetch) ? rdata : '0;

    // stores return nothing
    assign dataRdata = (owner == ownerData && !cmd.isStore) ? rdata : '0;

endmodule

`default_nettype wire

// ==== hdl/byteSequencer.sv ====
`timescale 1ns/1ns
`default_nettype none

module byteSequencer
    import memCtrlPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              advance,

    input  logic              startPulse,
    input  memReq_t           cmd,

    output memPort_t          memPort,
    input  logic [BYTE_W-1:0] memRdata,

    output logic              finishPulse,
    output logic [WORD_W-1:0] rdata
);

    // control state
    logic     active;
    byteIdx_t count;
    logic     inFlight;

    // latched command
    logic [ADDR_W-1:0] baseAddr;
    logic [WORD_W-1:0] storeData;
    byteIdx_t          lastIdx;
    logic              isStore;

    // byte read that is one cycle in flight
    byteIdx_t          flightLane;
    logic              flightLast;

    // load result, built one lane at a time
    logic [WORD_W-1:0] asmWord;

    logic     lastByte;
    byteIdx_t portIdx;
    logic     finishNext;

    assign lastByte = (count == lastIdx);

    // finishes on the last captured read, or on the last store byte
    assign finishNext = (inFlight && flightLast) || (active && isStore && lastByte);

    always_ff @(posedge clk) begin
        if (rst) begin
            active      <= 1'b0;
            count       <= '0;
            inFlight    <= 1'b0;
            finishPulse <= 1'b0;
        end else if (advance) begin
            finishPulse <= finishNext;
            if (startPulse) begin
                active   <= 1'b1;
                count    <= '0;
                inFlight <= 1'b0;
            end else if (active) begin
                // loads have a read in flight after each issue
                inFlight <= !isStore;
                if (lastByte) begin
                    active <= 1'b0;
                end else begin
                    count <= count + 1'b1;
                end
            end else begin
                inFlight <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            if (startPulse) begin
                baseAddr  <= cmd.addr;
                storeData <= cmd.wdata;
                lastIdx   <= byteIdx_t'(cmd.len - 3'd1);
                isStore   <= cmd.isStore;
                // upper lanes of short loads read as zero
                asmWord   <= '0;
            end else if (inFlight) begin
                asmWord[BYTE_W*flightLane +: BYTE_W] <= memRdata;
            end

            if (active) begin
                flightLane <= count;
                flightLast <= lastByte;
            end
        end
    end

    // while frozen, keep the pending read address on the port so the
    // RAM still presents that byte when the pipeline moves again
    assign portIdx = (!advance && inFlight) ? flightLane : count;

    always_comb begin
        memPort.addr  = baseAddr + ADDR_W'(portIdx);
        memPort.wdata = storeData[BYTE_W*count +: BYTE_W];
        memPort.write = active && isStore && advance;
    end

    assign rdata = asmWord;

endmodule

`default_nettype wire

// ==== hdl/memCtrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module memCtrl
    import memCtrlPkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              ioBufferFull,

    // instruction fetch client
    input  logic              fetchEn,
    input  logic [ADDR_W-1:0] fetchAddr,
    output logic              fetchDone,
    output logic [WORD_W-1:0] fetchInst,

    // load/store client
    input  logic              dataEn,
    input  memReq_t           dataReq,
    output logic              dataDone,
    output logic [WORD_W-1:0] dataRdata,

    // byte-wide RAM
    output memPort_t          memPort,
    input  logic [BYTE_W-1:0] memRdata,

    output memOwner_t         busyOwner
);

    logic              advance;
    logic              startPulse;
    memReq_t           cmd;
    logic              finishPulse;
    logic [WORD_W-1:0] rdata;

    // whole controller holds while the cpu stalls or io is full
    assign advance = rdy && !ioBufferFull;

    memArbiter u_memArbiter (
        .clk        (clk),
        .rst        (rst),
        .advance    (advance),
        .fetchEn    (fetchEn),
        .fetchAddr  (fetchAddr),
        .dataEn     (dataEn),
        .dataReq    (dataReq),
        .finishPulse(finishPulse),
        .rdata      (rdata),
        .startPulse (startPulse),
        .cmd        (cmd),
        .busyOwner  (busyOwner),
        .fetchDone  (fetchDone),
        .fetchInst  (fetchInst),
        .dataDone   (dataDone),
        .dataRdata  (dataRdata)
    );

    byteSequencer u_byteSequencer (
        .clk        (clk),
        .rst        (rst),
        .advance    (advance),
        .startPulse (startPulse),
        .cmd        (cmd),
        .memPort    (memPort),
        .memRdata   (memRdata),
        .finishPulse(finishPulse),
        .rdata      (rdata)
    );

endmodule

`default_nettype wire

// ==== bench/ramModel.sv ====
`timescale 1ns/1ns
`default_nettype none

module ramModel
    import memCtrlPkg::*;
#(
    parameter int DEPTH = 1024
)
(
    input  logic              clk,
    input  memPort_t          port,
    output logic [BYTE_W-1:0] rdata
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [BYTE_W-1:0] mem [DEPTH];
    logic [IDX_W-1:0]  idx;

    // address wraps inside the array
    assign idx = port.addr[IDX_W-1:0];

    // one-cycle read latency, write on the same edge
    always_ff @(posedge clk) begin
        if (port.write) begin
            mem[idx] <= port.wdata;
        end
        rdata <= mem[idx];
    end

endmodule

`default_nettype wire

// ==== bench/tbMemCtrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module tbMemCtrl
    import memCtrlPkg::*;
();

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int RAM_DEPTH    = 1024;
    localparam int SEED         = 32'hb360_0252;
    localparam int N_FETCH      = 20;
    localparam int N_MIXED      = 60;
    localparam int N_PRIO       = 6;
    localparam int N_STALL      = 80;
    localparam int TOTAL_XFERS  = N_FETCH + N_MIXED + 2 * N_PRIO + N_STALL;
    localparam int STALL_BUDGET = 600;
    localparam int CYCLE_LIMIT  = TOTAL_XFERS * 40 + STALL_BUDGET + 200;
    localparam int WINDOW       = 64;

    logic              clk;
    logic              rst;
    logic              rdy;
    logic              ioBufferFull;
    logic              fetchEn;
    logic [ADDR_W-1:0] fetchAddr;
    logic              fetchDone;
    logic [WORD_W-1:0] fetchInst;
    logic              dataEn;
    memReq_t           dataReq;
    logic              dataDone;
    logic [WORD_W-1:0] dataRdata;
    memPort_t          memPort;
    logic [BYTE_W-1:0] memRdata;
    memOwner_t         busyOwner;

    logic [BYTE_W-1:0] shadow [RAM_DEPTH];
    logic [WORD_W-1:0] fetchExp [$];
    logic [WORD_W-1:0] dataExp [$];
    int                issued;
    int                checked;
    int                cycles;
    int                stallLeft;

    memCtrl u_memCtrl (
        .clk         (clk),
        .rst         (rst),
        .rdy         (rdy),
        .ioBufferFull(ioBufferFull),
        .fetchEn     (fetchEn),
        .fetchAddr   (fetchAddr),
        .fetchDone   (fetchDone),
        .fetchInst   (fetchInst),
        .dataEn      (dataEn),
        .dataReq     (dataReq),
        .dataDone    (dataDone),
        .dataRdata   (dataRdata),
        .memPort     (memPort),
        .memRdata    (memRdata),
        .busyOwner   (busyOwner)
    );

    ramModel #(.DEPTH(RAM_DEPTH)) u_ram (
        .clk  (clk),
        .port (memPort),
        .rdata(memRdata)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic reportFail(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    // expected little-endian word from the shadow bytes, upper lanes zero
    function automatic logic [WORD_W-1:0] refRead(input logic [ADDR_W-1:0] addr, input int len);
        logic [WORD_W-1:0] w;
        w = '0;
        for (int i = 0; i < len; i++) begin
            w[BYTE_W*i +: BYTE_W] = shadow[(int'(addr) + i) % RAM_DEPTH];
        end
        return w;
    endfunction

    task automatic shadowWrite(input logic [ADDR_W-1:0] addr, input int len,
                               input logic [WORD_W-1:0] wdata);
        for (int i = 0; i < len; i++) begin
            shadow[(int'(addr) + i) % RAM_DEPTH] = wdata[BYTE_W*i +: BYTE_W];
        end
    endtask

    function automatic xferLen_t pickLen();
        case ($urandom % 3)
            0: return 3'd1;
            1: return 3'd2;
            default: return 3'd4;
        endcase
    endfunction

    // stall levels for the coming cycle
    task automatic setStall(input logic allow);
        int pick;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        if (allow && stallLeft > 0 && ($urandom % 4) == 0) begin
            pick = int'($urandom % 3);
            stallLeft--;
            if (pick != 1) rdy = 1'b0;
            if (pick != 0) ioBufferFull = 1'b1;
        end
    endtask

    // cycle counter and run limit
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > CYCLE_LIMIT) begin
                $display("timeout: run went past %0d cycles", CYCLE_LIMIT);
                $display("TB FAILED");
                $fatal(1);
            end
        end
    end

    // compares every reply with the queued expected value
    initial begin
        logic [WORD_W-1:0] exp;
        forever begin
            @(negedge clk);
            #1;
            if (!rst) begin
                assert ((rdy && !ioBufferFull) || !memPort.write)
                    else reportFail("memory write seen during a stalled cycle");
                if (fetchDone) begin
                    assert (fetchExp.size() > 0)
                        else reportFail("fetch done with no fetch pending");
                    exp = fetchExp.pop_front();
                    assert (fetchInst == exp)
                        else reportFail($sformatf("mismatch at %0t: fetchInst %h expected %h",
                                                  $time, fetchInst, exp));
                    checked++;
                end
                if (dataDone) begin
                    assert (dataExp.size() > 0)
                        else reportFail("data done with no data transfer pending");
                    exp = dataExp.pop_front();
                    assert (dataRdata == exp)
                        else reportFail($sformatf("mismatch at %0t: dataRdata %h expected %h",
                                                  $time, dataRdata, exp));
                    checked++;
                end
            end
        end
    end

    // called just after a falling edge
    task automatic runXfer(input logic isFetch, input logic [ADDR_W-1:0] addr,
                           input xferLen_t len, input logic isStore,
                           input logic [WORD_W-1:0] wdata, input logic allowStall,
                           input logic checkLatency);
        int   startCycle;
        logic seen;
        startCycle = cycles;
        if (isFetch) begin
            fetchAddr = addr;
            fetchEn   = 1'b1;
            fetchExp.push_back(refRead(addr, 4));
        end else begin
            dataReq = '{addr: addr, wdata: wdata, len: len, isStore: isStore};
            dataEn  = 1'b1;
            if (isStore) begin
                shadowWrite(addr, int'(len), wdata);
                dataExp.push_back('0);
            end else begin
                dataExp.push_back(refRead(addr, int'(len)));
            end
        end
        issued++;
        seen = 1'b0;
        while (!seen) begin
            @(negedge clk);
            setStall(allowStall);
            #2;
            seen = isFetch ? fetchDone : dataDone;
        end
        if (checkLatency && isFetch) begin
            assert (cycles - startCycle == 7)
                else reportFail($sformatf("fetch done after %0d cycles instead of 7",
                                          cycles - startCycle));
        end
        fetchEn = 1'b0;
        dataEn  = 1'b0;
    endtask

    task automatic randomOp(input int window, input logic allowStall);
        int                kind;
        logic [ADDR_W-1:0] addr;
        kind = int'($urandom % 3);
        addr = ADDR_W'($urandom % window);
        runXfer(kind == 0, addr, pickLen(), kind == 2, $urandom, allowStall, 1'b0);
    endtask

    // data and fetch raised together, data must finish first
    task automatic runPair(input logic [ADDR_W-1:0] fAddr, input logic [ADDR_W-1:0] dAddr,
                           input xferLen_t len);
        logic dataSeen;
        logic fetchSeen;
        fetchAddr = fAddr;
        dataReq   = '{addr: dAddr, wdata: '0, len: len, isStore: 1'b0};
        fetchEn   = 1'b1;
        dataEn    = 1'b1;
        fetchExp.push_back(refRead(fAddr, 4));
        dataExp.push_back(refRead(dAddr, int'(len)));
        issued += 2;
        dataSeen  = 1'b0;
        fetchSeen = 1'b0;
        while (!fetchSeen) begin
            @(negedge clk);
            setStall(1'b0);
            #2;
            if (!dataSeen) begin
                assert (busyOwner == ownerData)
                    else reportFail($sformatf("mismatch at %0t: busyOwner %0d expected ownerData",
                                              $time, busyOwner));
                assert (!fetchDone) else reportFail("fetch finished before the data transfer");
                if (dataDone) begin
                    dataSeen = 1'b1;
                    dataEn   = 1'b0;
                end
            end else begin
                assert (busyOwner == ownerFetch)
                    else reportFail($sformatf("mismatch at %0t: busyOwner %0d expected ownerFetch",
                                              $time, busyOwner));
                fetchSeen = fetchDone;
            end
        end
        fetchEn = 1'b0;
    endtask

    initial begin
        logic [BYTE_W-1:0] b;
        void'($urandom(SEED));
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        fetchEn      = 1'b0;
        fetchAddr    = '0;
        dataEn       = 1'b0;
        dataReq      = '0;
        issued       = 0;
        checked      = 0;
        stallLeft    = STALL_BUDGET;

        for (int i = 0; i < RAM_DEPTH; i++) begin
            b = BYTE_W'($urandom);
            shadow[i]    = b;
            u_ram.mem[i] = b;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle outputs after reset
        repeat (3) begin
            @(negedge clk);
            #2;
            assert (!fetchDone && !dataDone && !memPort.write && busyOwner == ownerNone)
                else reportFail($sformatf("mismatch at %0t: outputs not idle after reset",
                                          $time));
        end

        for (int i = 0; i < N_FETCH; i++) begin
            runXfer(1'b1, ADDR_W'($urandom % (RAM_DEPTH - 4)), 3'd4, 1'b0, '0, 1'b0, 1'b1);
        end

        // small window so stores are read back
        for (int i = 0; i < N_MIXED; i++) begin
            randomOp(WINDOW, 1'b0);
        end

        for (int i = 0; i < N_PRIO; i++) begin
            runPair(ADDR_W'($urandom % WINDOW), ADDR_W'($urandom % WINDOW), pickLen());
        end

        for (int i = 0; i < N_STALL; i++) begin
            randomOp(WINDOW, 1'b1);
        end

        @(negedge clk);
        setStall(1'b0);
        #2;

        for (int i = 0; i < RAM_DEPTH; i++) begin
            assert (u_ram.mem[i] == shadow[i])
                else reportFail($sformatf("mismatch at %0t: RAM byte %0d is %h expected %h",
                                          $time, i, u_ram.mem[i], shadow[i]));
        end

        if (checked == issued && fetchExp.size() == 0 && dataExp.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("checked %0d replies of %0d transfers", checked, issued);
            $display("TB FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

// ==== all.f ====
hdl/memCtrlPkg.sv
hdl/memArbiter.sv
hdl/byteSequencer.sv
hdl/memCtrl.sv
bench/ramModel.sv
bench/tbMemCtrl.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f all.f --top-module tbMemCtrl -o simMemCtrl

# the log decides pass or fail
./obj_dir/simMemCtrl > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
    echo "simulation failed"
    exit 1
fi

if ! grep -q "TB PASSED" sim.log; then
    echo "no pass message in log"
    exit 1
fi

echo "simulation passed"
